/* bt_bridge.f */
+incdir+include
src/bt_bridge_pkg.sv
src/word_fifo_if.sv
src/word_fifo.sv
src/word_serializer.sv
src/word_deserializer.sv
src/link_controller.sv
src/bt_bridge.sv
sim/bt_bridge_asserts.sv
sim/bt_bridge_tb.sv

/* include/bt_bridge_cfg.svh */
/*
	bt_bridge configuration
	FIFO depth, serial bit period and the reply terminator word
*/
`ifndef BT_BRIDGE_CFG_SVH
`define BT_BRIDGE_CFG_SVH

// words per FIFO, must be a power of two
`define BT_FIFO_DEPTH 16

`define BT_FIFO_COUNT_W ($clog2(`BT_FIFO_DEPTH) + 1)

`define BT_BIT_CYCLES 8 // clocks per serial bit

`define BT_REPLY_END 16'h0d0a // CR LF

`endif

/* sim/bt_bridge_asserts.sv */
/*
	bt_bridge_asserts
	concurrent checks on controller sequencing and serial line behaviour
*/
`timescale 1ns/1ps

module bt_bridge_asserts (
	input logic clock,
	input logic reset,
	input logic line_quiet, // block not framing
	input logic line,
	input logic tx_start,
	input logic rx_arm,
	input logic wr_en,
	input logic wr_full,
	input logic pulse
);
	int unsigned fail_count = 0; // read by the testbench at the end

	quiet_line_high: assert property (@(posedge clock) disable iff (reset) line_quiet |-> line)
	else
	begin
		fail_count++;
		$error("serial line low while the serializer is idle");
	end

	start_arm_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(tx_start && rx_arm))
	else
	begin
		fail_count++;
		$error("tx_start and rx_arm high together");
	end

	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		!(wr_en && wr_full))
	else
	begin
		fail_count++;
		$error("FIFO write while full");
	end

	done_one_cycle: assert property (@(posedge clock) disable iff (reset) pulse |=> !pulse)
	else
	begin
		fail_count++;
		$error("done pulse longer than one cycle");
	end

endmodule

bind word_serializer bt_bridge_asserts ser_chk (
	.clock(clock), .reset(reset),
	.line_quiet(!busy), .line(txd),
	.tx_start(start), .rx_arm(1'b0),
	.wr_en(1'b0), .wr_full(1'b0),
	.pulse(done)
);

bind link_controller bt_bridge_asserts ctrl_chk (
	.clock(clock), .reset(reset),
	.line_quiet(1'b0), .line(1'b1),
	.tx_start(tx_start), .rx_arm(rx_arm),
	.wr_en(state == bt_bridge_pkg::load_sensor), .wr_full(tx_wr.full),
	.pulse(rx_done)
);

/* sim/bt_bridge_tb.sv */
/*
	bt_bridge testbench
	sensor and command mode runs against a radio module model on txd and rxd
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module bt_bridge_tb;
	import bt_bridge_pkg::*;

	typedef bt_word_t word_q_t[$];

	localparam int BIT = `BT_BIT_CYCLES;
	localparam int DEPTH = `BT_FIFO_DEPTH;
	localparam int FRAMES = 2 * DEPTH + 5 + 6 + 2 * DEPTH + 1; // sensor, command and reply frames
	localparam int LIMIT = FRAMES * (18 * BIT + 24) + 4 * 18 * BIT + 1000;

	logic clock;
	logic reset;
	logic rxd;
	logic want_at;
	logic begin_connection;
	logic user_data_loaded;
	logic user_data_done;
	logic reply_access;
	logic reply_finished;
	bt_word_t user_data;
	bt_word_t sensor_data;
	logic txd;
	logic bt_enable;
	link_state_t state;
	bt_word_t reply_data;
	logic [`BT_FIFO_COUNT_W-1:0] tx_count;
	logic [`BT_FIFO_COUNT_W-1:0] reply_count;

	word_q_t sent; // words decoded from txd
	logic [31:0] lcg_state = 32'h7cc6571e;
	int reply_frames = 0; // reply frames fully driven on rxd
	int checks = 0;
	int mismatches = 0;
	int failures = 0;
	int cycles = 0;

	bt_bridge UUT (
		.clock(clock), .reset(reset), .rxd(rxd), .want_at(want_at),
		.begin_connection(begin_connection), .user_data_loaded(user_data_loaded),
		.user_data_done(user_data_done), .reply_access(reply_access),
		.reply_finished(reply_finished), .user_data(user_data), .sensor_data(sensor_data),
		.txd(txd), .bt_enable(bt_enable), .state(state), .reply_data(reply_data),
		.tx_count(tx_count), .reply_count(reply_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	function automatic bt_word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// radio answer, every sent word xor 5a5a then the terminator
	function automatic word_q_t expected_reply(word_q_t words);
		word_q_t r;
		foreach (words[i])
			r.push_back(words[i] ^ 16'h5a5a);
		r.push_back(`BT_REPLY_END);
		return r;
	endfunction

	task automatic check_word(input string name, input bt_word_t exp, input bt_word_t act);
		checks++;
		if (exp !== act)
		begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_state(input string name, input link_state_t exp, input link_state_t act);
		checks++;
		if (exp !== act)
		begin
			mismatches++;
			$display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act)
		begin
			mismatches++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			mismatches++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic wait_for_state(input link_state_t s);
		@(negedge clock);
		while (state !== s)
			@(negedge clock);
	endtask

	task automatic drive_rx_frame(input bt_word_t w);
		logic [17:0] f;
		f = {1'b1, w, 1'b0};
		for (int i = 0; i < 18; i++)
		begin
			rxd = f[i];
			repeat (BIT) @(negedge clock);
		end
		reply_frames++; // stop bit complete
		rxd = 1'b1;
		repeat (2 * BIT) @(negedge clock); // idle gap so the receiver re-arms
	endtask

	task automatic run_sensor_mode(input bt_word_t value);
		sent.delete();
		sensor_data = value;
		want_at = 1'b0;
		begin_connection = 1'b1;
		wait_for_state(done);
		check_count("sensor frame count", DEPTH, sent.size());
		foreach (sent[i])
			check_word("sensor frame", value, sent[i]);
		check_count("tx_count after sensor run", 0, tx_count);
		begin_connection = 1'b0;
		@(negedge clock);
		check_state("sensor run end", idle, state);
	endtask

	task automatic run_command_mode(input int n, output word_q_t host);
		bt_word_t w;
		host.delete();
		sent.delete();
		user_data_done = 1'b0;
		want_at = 1'b1;
		begin_connection = 1'b1;
		for (int i = 0; i < n; i++)
		begin
			w = next_random();
			host.push_back(w);
			wait_for_state(wait_user_data);
			user_data = w;
			user_data_loaded = 1'b1;
			user_data_done = (i == n - 1); // read only in rest_user
			@(negedge clock);
			user_data_loaded = 1'b0;
		end
		check_level("bt_enable in command mode", 1'b1, bt_enable);
		wait_for_state(wait_user_demand);
		user_data_done = 1'b0;
		check_count("command frame count", n, sent.size());
		foreach (host[i])
			if (i < sent.size())
				check_word("command frame order", host[i], sent[i]);
	endtask

	task automatic read_reply_words(input word_q_t exp_words);
		int stored;
		stored = (exp_words.size() > DEPTH) ? DEPTH : exp_words.size();
		check_count("reply_count after reply", stored, reply_count);
		for (int i = 0; i < stored; i++)
		begin
			if (i > 0)
				wait_for_state(wait_user_demand);
			check_word("reply_data", exp_words[i], reply_data);
			reply_access = 1'b1;
			reply_finished = (i == stored - 1); // held through rest_read
			@(negedge clock);
			reply_access = 1'b0;
			wait_for_state(rest_read);
			check_count("reply_count after read", stored - i - 1, reply_count);
		end
		wait_for_state(done);
		reply_finished = 1'b0;
	endtask

	// radio model receive side, mid-bit sampling of txd
	initial
	begin : radio_rx
		bt_word_t w;
		forever
		begin
			@(negedge txd);
			repeat (BIT / 2) @(negedge clock);
			if (txd !== 1'b0)
			begin
				failures++;
				$display("start bit on txd did not stay low");
			end
			for (int i = 0; i < 16; i++)
			begin
				repeat (BIT) @(negedge clock);
				w[i] = txd;
			end
			repeat (BIT) @(negedge clock);
			if (txd !== 1'b1)
			begin
				failures++;
				$display("stop bit on txd was not high");
			end
			sent.push_back(w);
		end
	end

	// radio model answer, only seen in command mode
	initial
	begin : radio_answer
		word_q_t words;
		forever
		begin
			wait_for_state(receive_reply);
			words = expected_reply(sent);
			reply_frames = 0;
			foreach (words[i])
				drive_rx_frame(words[i]);
			wait_for_state(wait_user_demand);
		end
	end

	initial
	begin : run_limit
		while (cycles < LIMIT)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin : main
		word_q_t host;
		word_q_t reply;
		reset = 1'b1;
		rxd = 1'b1;
		want_at = 1'b0;
		begin_connection = 1'b0;
		user_data_loaded = 1'b0;
		user_data_done = 1'b0;
		reply_access = 1'b0;
		reply_finished = 1'b0;
		user_data = '0;
		sensor_data = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_state("state after reset", idle, state);
		check_level("txd after reset", 1'b1, txd);
		check_count("tx_count after reset", 0, tx_count);
		check_count("reply_count after reset", 0, reply_count);

		run_sensor_mode(next_random());
		run_sensor_mode(next_random());

		run_command_mode(5, host);
		reply = expected_reply(host);
		check_count("reply frames before wait_user_demand", reply.size(), reply_frames);
		read_reply_words(reply);
		repeat (3 * 18 * BIT) @(negedge clock); // quiet line expected in done
		check_count("frames after done", host.size(), sent.size());
		check_level("txd in done", 1'b1, txd);
		check_state("state holds done", done, state);
		begin_connection = 1'b0;
		@(negedge clock);
		check_state("command run end", idle, state);

		run_command_mode(DEPTH, host); // reply one word longer than the FIFO
		reply = expected_reply(host);
		check_count("long reply frames before wait_user_demand", reply.size(), reply_frames);
		read_reply_words(reply);
		begin_connection = 1'b0;
		@(negedge clock);
		check_state("long reply run end", idle, state);

		failures += UUT.u_ser.ser_chk.fail_count;
		failures += UUT.u_ctrl.ctrl_chk.fail_count;
		$display("checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* src/bt_bridge.sv */
/*
	bt_bridge
	host register bridge to a serial radio module
	controller, transmit and reply FIFOs, serializer and deserializer
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module bt_bridge (
	input logic clock,
	input logic reset,
	input logic rxd,
	input logic want_at,
	input logic begin_connection,
	input logic user_data_loaded,
	input logic user_data_done,
	input logic reply_access,
	input logic reply_finished,
	input bt_bridge_pkg::bt_word_t user_data,
	input bt_bridge_pkg::bt_word_t sensor_data,
	output logic txd,
	output logic bt_enable,
	output bt_bridge_pkg::link_state_t state,
	output bt_bridge_pkg::bt_word_t reply_data,
	output logic [`BT_FIFO_COUNT_W-1:0] tx_count,
	output logic [`BT_FIFO_COUNT_W-1:0] reply_count
);
	import bt_bridge_pkg::*;

	word_fifo_if tx_q ();
	word_fifo_if reply_q ();

	logic tx_start;
	logic tx_done;
	logic rx_arm;
	logic rx_done;
	bt_word_t rx_word;

	assign bt_enable = want_at; // radio in command mode when host asks for it
	assign reply_data = reply_q.dout;
	assign tx_count = tx_q.count;
	assign reply_count = reply_q.count;

	link_controller u_ctrl (
		.clock(clock),
		.reset(reset),
		.want_at(want_at),
		.begin_connection(begin_connection),
		.user_data_loaded(user_data_loaded),
		.user_data_done(user_data_done),
		.reply_access(reply_access),
		.reply_finished(reply_finished),
		.user_data(user_data),
		.sensor_data(sensor_data),
		.tx_done(tx_done),
		.rx_done(rx_done),
		.rx_word(rx_word),
		.tx_start(tx_start),
		.rx_arm(rx_arm),
		.state(state),
		.tx_wr(tx_q.writer),
		.tx_rd(tx_q.reader),
		.reply_wr(reply_q.writer),
		.reply_rd(reply_q.reader)
	);

	word_fifo u_tx_fifo (.clock(clock), .reset(reset), .q(tx_q.fifo));
	word_fifo u_reply_fifo (.clock(clock), .reset(reset), .q(reply_q.fifo));

	word_serializer u_ser (
		.clock(clock),
		.reset(reset),
		.start(tx_start),
		.data(tx_q.dout),
		.done(tx_done),
		.txd(txd)
	);

	word_deserializer u_deser (
		.clock(clock),
		.reset(reset),
		.arm(rx_arm),
		.rxd(rxd),
		.done(rx_done),
		.word(rx_word)
	);

endmodule

/* src/bt_bridge_pkg.sv */
/*
	bt_bridge types
	data word and the link controller state encoding
*/
package bt_bridge_pkg;

	typedef logic [15:0] bt_word_t; // one FIFO entry, one serial frame payload

	typedef enum logic [3:0] {
		idle             = 4'h0,
		wait_user_data   = 4'h1,
		load_user        = 4'h2,
		rest_user        = 4'h3,
		load_sensor      = 4'h4,
		rest_sensor      = 4'h5,
		load_tx          = 4'h6,
		send_tx          = 4'h7,
		rest_tx          = 4'h8,
		receive_reply    = 4'h9,
		load_reply       = 4'ha,
		rest_reply       = 4'hb,
		wait_user_demand = 4'hc,
		read_reply       = 4'hd,
		rest_read        = 4'he,
		done             = 4'hf
	} link_state_t;

endpackage

/* src/link_controller.sv */
/*
	link_controller
	sequences sensor or command mode transfers through the transmit FIFO,
	then collects the reply into the response FIFO for the host
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module link_controller (
	input logic clock,
	input logic reset,
	input logic want_at,
	input logic begin_connection,
	input logic user_data_loaded,
	input logic user_data_done,
	input logic reply_access,
	input logic reply_finished,
	input bt_bridge_pkg::bt_word_t user_data,
	input bt_bridge_pkg::bt_word_t sensor_data,
	input logic tx_done,
	input logic rx_done,
	input bt_bridge_pkg::bt_word_t rx_word,
	output logic tx_start,
	output logic rx_arm,
	output bt_bridge_pkg::link_state_t state,
	word_fifo_if.writer tx_wr,
	word_fifo_if.reader tx_rd,
	word_fifo_if.writer reply_wr,
	word_fifo_if.reader reply_rd
);
	import bt_bridge_pkg::*;

	link_state_t next_state;
	bt_word_t last_stored; // last reply word seen, stored or not

	assign tx_wr.din = want_at ? user_data : sensor_data; // host word in command mode
	assign tx_wr.wr_en = (state == load_user || state == load_sensor) && !tx_wr.full;
	assign tx_rd.rd_en = (state == send_tx) && tx_done; // pop once the head is on the line
	assign reply_wr.din = rx_word;
	assign reply_wr.wr_en = (state == load_reply) && !reply_wr.full;
	assign reply_rd.rd_en = (state == read_reply);

	assign tx_start = (state == send_tx);
	assign rx_arm = (state == receive_reply);

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (begin_connection)
					next_state = want_at ? wait_user_data : load_sensor;
			wait_user_data:
				if (user_data_loaded)
					next_state = load_user;
			load_user:
				next_state = rest_user;
			rest_user:
				next_state = user_data_done ? load_tx : wait_user_data;
			load_sensor:
				next_state = rest_sensor;
			rest_sensor:
				next_state = tx_wr.full ? load_tx : load_sensor;
			load_tx:
				next_state = send_tx;
			send_tx:
				if (tx_done)
					next_state = rest_tx;
			rest_tx:
			begin
				if (!tx_rd.empty)
					next_state = load_tx;
				else
					next_state = want_at ? receive_reply : done; // replies only in command mode
			end
			receive_reply:
				if (rx_done)
					next_state = load_reply;
			load_reply:
				next_state = rest_reply;
			rest_reply:
				next_state = (last_stored == `BT_REPLY_END) ? wait_user_demand : receive_reply;
			wait_user_demand:
				if (reply_access)
					next_state = read_reply;
			read_reply:
				next_state = rest_read;
			rest_read:
				next_state = reply_finished ? done : wait_user_demand;
			done:
				if (!begin_connection)
					next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	always_ff @(posedge clock)
	begin
		if (state == load_reply)
			last_stored <= rx_word; // terminator check also covers dropped words
	end

endmodule

/* src/word_deserializer.sv */
/*
	word_deserializer
	hunts for a start edge while armed, samples each bit at mid period
	a low stop bit discards the word
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module word_deserializer (
	input logic clock,
	input logic reset,
	input logic arm,
	input logic rxd,
	output logic done,
	output bt_bridge_pkg::bt_word_t word
);
	import bt_bridge_pkg::*;

	localparam int CYC_W = $clog2(`BT_BIT_CYCLES + 1);
	localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`BT_BIT_CYCLES - 1);
	localparam logic [CYC_W-1:0] HALF_CYC = CYC_W'(`BT_BIT_CYCLES / 2);

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic fall;
	logic sample;
	logic busy;
	logic [CYC_W-1:0] cyc;
	logic [4:0] bit_idx; // 0 start, 1..16 data, 17 stop
	bt_word_t shift;

	assign fall = rx_prev && !rx_sync;
	assign sample = busy && (cyc == LAST_CYC);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1; // line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cyc <= '0;
			bit_idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (arm && fall)
				begin
					busy <= 1'b1;
					cyc <= HALF_CYC; // first sample lands mid start bit
					bit_idx <= '0;
				end
			end
			else if (sample)
			begin
				cyc <= '0;
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 5'd0 && rx_sync)
					busy <= 1'b0; // glitch, not a start bit
				else if (bit_idx == 5'd17)
				begin
					busy <= 1'b0;
					done <= rx_sync; // framing error gives no done
				end
			end
			else
				cyc <= cyc + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (sample && bit_idx != 5'd0 && bit_idx != 5'd17)
			shift <= {rx_sync, shift[15:1]}; // lsb arrives first
		if (sample && bit_idx == 5'd17 && rx_sync)
			word <= shift;
	end

endmodule

/* src/word_fifo.sv */
/*
	word_fifo
	single clock circular buffer of bt_word_t entries
	head word shown combinationally, count derived from the pointers
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module word_fifo (
	input logic clock,
	input logic reset,
	word_fifo_if.fifo q
);
	import bt_bridge_pkg::*;

	localparam int ADDR_W = $clog2(`BT_FIFO_DEPTH);

	bt_word_t mem [`BT_FIFO_DEPTH];
	logic [ADDR_W:0] wr_ptr; // extra msb tells full from empty
	logic [ADDR_W:0] rd_ptr;
	logic do_write;
	logic do_read;

	assign do_write = q.wr_en && !q.full; // write while full is dropped
	assign do_read = q.rd_en && !q.empty;

	assign q.empty = (wr_ptr == rd_ptr);
	assign q.full = ((wr_ptr ^ rd_ptr) == {1'b1, {ADDR_W{1'b0}}});
	assign q.count = wr_ptr - rd_ptr;
	assign q.dout = mem[rd_ptr[ADDR_W-1:0]];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_write)
			mem[wr_ptr[ADDR_W-1:0]] <= q.din;
	end

endmodule

/* src/word_fifo_if.sv */
/*
	word_fifo_if
	write, read and status signals of one word FIFO
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

interface word_fifo_if;
	import bt_bridge_pkg::*;

	logic wr_en;
	bt_word_t din;
	logic rd_en;
	bt_word_t dout; // head word, valid while not empty
	logic full;
	logic empty;
	logic [`BT_FIFO_COUNT_W-1:0] count;

	modport writer (output wr_en, output din, input full);
	modport reader (output rd_en, input dout, input empty, input count);
	modport fifo (
		input wr_en, input din, input rd_en,
		output dout, output full, output empty, output count
	);

endinterface

/* src/word_serializer.sv */
/*
	word_serializer
	sends one word as start bit, 16 data bits lsb first, stop bit
	each bit held for BT_BIT_CYCLES clocks
*/
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module word_serializer (
	input logic clock,
	input logic reset,
	input logic start,
	input bt_bridge_pkg::bt_word_t data,
	output logic done,
	output logic txd
);
	localparam int CYC_W = $clog2(`BT_BIT_CYCLES + 1);
	localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`BT_BIT_CYCLES - 1);

	logic [17:0] frame; // bit 0 is on the line, ones shift in behind
	logic [CYC_W-1:0] cyc;
	logic [4:0] bit_idx;
	logic busy;

	assign txd = frame[0];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame <= '1;
			cyc <= '0;
			bit_idx <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (start && !done) // held start is not retaken in the done cycle
				begin
					frame <= {1'b1, data, 1'b0};
					cyc <= '0;
					bit_idx <= '0;
					busy <= 1'b1;
				end
			end
			else if (cyc == LAST_CYC)
			begin
				cyc <= '0;
				frame <= {1'b1, frame[17:1]};
				if (bit_idx == 5'd17) // end of stop bit
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				cyc <= cyc + 1'b1;
		end
	end

endmodule
